// ==== rvv_decode.f ====
rtl/rvv_decode_pkg.sv
rtl/rvv_inst_capture.sv
rtl/rvv_op_classify.sv
rtl/rvv_operand_geometry.sv
rtl/rvv_uop_expand.sv
rtl/rvv_decode_top.sv
verif/rvv_decode_assertions.sv
verif/rvv_decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= rvv_decode_tb
FILELIST  ?= rvv_decode.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/rvv_decode_tb.sv ====
`timescale 1ns/1ps

module rvv_decode_tb;
  import rvv_decode_pkg::*;

  localparam int NUM_DE_UOP  = 2;
  localparam int NUM_TESTS   = 6;
  localparam int VECTORS     = 64;
  localparam int DRAIN       = 4;
  localparam int WATCHDOG_NS = (NUM_TESTS * (VECTORS + DRAIN) + 20) * 20;

  localparam funct6_t SINGLE_OPS [11] = '{F6_VADD, F6_VRSUB, F6_VAND, F6_VOR, F6_VXOR,
                                          F6_VADC, F6_VMERGE, F6_VSLL, F6_VSRL, F6_VSRA,
                                          F6_VSLIDEUP};
  localparam funct6_t START_OPS [5]   = '{F6_VADD, F6_VSRA, F6_VSLIDEUP, F6_VMSNE, F6_VNSRL};
  localparam funct6_t UNKNOWN_OPS [4] = '{6'b000001, 6'b000010, 6'b010010, 6'b111111};

  typedef struct packed {
    logic [NUM_DE_UOP-1:0] valid;
    uop_t [NUM_DE_UOP-1:0] uop;
  } expect_t;

  logic                  clk;
  logic                  arst_n;
  logic                  inst_valid;
  inst_in_t              inst;
  uop_index_t            uop_index_remain;
  logic [NUM_DE_UOP-1:0] uop_valid;
  uop_t [NUM_DE_UOP-1:0] uop;

  expect_t               exp_stage;
  expect_t               exp_out;
  logic [NUM_DE_UOP-1:0] exp_valid;
  uop_t [NUM_DE_UOP-1:0] exp_uop;

  // fields of the next instruction
  logic       vld;
  funct6_t    f6;
  funct3_t    f3;
  logic       vm;
  vreg_idx_t  vs2;
  vreg_idx_t  imm;
  vreg_idx_t  vd;
  vsew_t      sew;
  vlmul_t     lmul;
  vstart_t    vst;
  uop_index_t remain;

  logic [31:0] lfsr = 32'hedf7aba8;
  int          seen;
  int          total;

  rvv_decode_top #(
    .NUM_DE_UOP (NUM_DE_UOP)
  ) i_rvv_decode_top (
    .clk              (clk),
    .arst_n           (arst_n),
    .inst_valid       (inst_valid),
    .inst             (inst),
    .uop_index_remain (uop_index_remain),
    .uop_valid        (uop_valid),
    .uop              (uop)
  );

  bind rvv_decode_top rvv_decode_assertions #(
    .NUM_DE_UOP (NUM_DE_UOP)
  ) i_rvv_decode_assertions (
    .clk       (clk),
    .arst_n    (arst_n),
    .uop_valid (uop_valid),
    .uop       (uop),
    .exp_valid (rvv_decode_tb.exp_valid),
    .exp_uop   (rvv_decode_tb.exp_uop)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic int lmul_regs(vlmul_t l);
    case (l)
      LMUL2:   return 2;
      LMUL4:   return 4;
      LMUL8:   return 8;
      default: return 1;
    endcase
  endfunction

  function automatic vreg_idx_t align_to(vreg_idx_t r, int n);
    return r & ~vreg_idx_t'(n - 1);
  endfunction

  function automatic logic aligned(vreg_idx_t r, int n);
    return (n <= 1) || ((r % n) == 0);
  endfunction

  function automatic eew_t eew_of(int bits);
    case (bits)
      1:       return EEW1;
      8:       return EEW8;
      16:      return EEW16;
      default: return EEW32;
    endcase
  endfunction

  function automatic string test_name(int t);
    case (t)
      0:       return "single-width and slide";
      1:       return "mask compares";
      2:       return "narrowing shifts";
      3:       return "whole-register move";
      4:       return "illegal encodings";
      default: return "start index";
    endcase
  endfunction

  // expected uops of one instruction, straight from the decode rules
  function automatic expect_t predict(logic v, inst_in_t in, uop_index_t rem);
    expect_t   e;
    uop_t      u;
    funct6_t   op;
    logic      vm_bit;
    logic      known;
    logic      legal;
    vreg_idx_t rs2;
    vreg_idx_t rimm;
    vreg_idx_t rd;
    int        regs;
    int        sew_bits;
    int        vs2_bits;
    int        vd_bits;
    int        emul_vd;
    int        emul_vs2;
    int        emul_max;
    int        sh;
    int        first;
    int        start;
    int        idx;
    e        = '0;
    op       = in.inst[26:21];
    vm_bit   = in.inst[20];
    rs2      = in.inst[19:15];
    rimm     = in.inst[14:10];
    rd       = in.inst[6:2];
    regs     = lmul_regs(in.vlmul);
    sew_bits = 8 << in.vsew;
    vs2_bits = sew_bits;
    vd_bits  = sew_bits;
    emul_vd  = regs;
    emul_vs2 = regs;
    known    = 1'b1;
    legal    = in.inst[9:7] == F3_OPIVI;
    case (op)
      F6_VADD, F6_VRSUB, F6_VAND, F6_VOR, F6_VXOR, F6_VSLL, F6_VSRL, F6_VSRA,
      F6_VSLIDEUP: known = 1'b1;
      F6_VADC:     legal = legal && !vm_bit;
      F6_VMERGE:   legal = legal && (!vm_bit || rs2 == '0);
      F6_VMSEQ, F6_VMSNE: begin
        emul_vd = 1;
        vd_bits = 1;
      end
      F6_VNSRL, F6_VNSRA: begin
        vs2_bits = (sew_bits == 32) ? 32 : 2 * sew_bits;
        emul_vs2 = (in.vlmul == LMUL_1_4 || in.vlmul == LMUL_1_2) ? 1 : 2 * regs;
        // a 64-bit or 16-register source does not exist
        if (sew_bits == 32 || regs == 8) begin
          emul_vd  = 0;
          emul_vs2 = 0;
        end
      end
      F6_VMVNRR: begin
        emul_vd  = rimm[2:0] + 1;
        emul_vs2 = emul_vd;
        legal    = legal && vm_bit && (rimm inside {5'd0, 5'd1, 5'd3, 5'd7});
      end
      default: begin
        known = 1'b0;
        legal = 1'b0;
      end
    endcase
    legal    = legal && aligned(rd, emul_vd) && aligned(rs2, emul_vs2);
    emul_max = (emul_vs2 > emul_vd) ? emul_vs2 : emul_vd;
    sh       = $clog2(VLEN / ((vs2_bits > vd_bits) ? vs2_bits : vd_bits));
    first    = in.vstart >> sh;
    start    = (first > rem) ? first : rem;
    for (int i = 0; i < NUM_DE_UOP; i++) begin
      idx        = start + i;
      e.valid[i] = v && legal && (idx < emul_max);
      u           = '0;
      u.funct6    = op;
      u.funct3    = in.inst[9:7];
      u.exe_unit  = (op == F6_VSLIDEUP) ? PMTRDT : ALU;
      u.vm        = vm_bit;
      u.v0_valid  = (op == F6_VADC) || (op == F6_VMERGE && !vm_bit);
      u.vd_index  = (vd_bits == 1) ? rd : rd + vreg_idx_t'(idx);
      u.vd_eew    = eew_of(vd_bits);
      u.vd_valid  = known;
      u.vs3_valid = vd_bits == 1;
      if (op == F6_VMVNRR) begin
        u.funct6    = F6_VMERGE;
        u.funct3    = F3_OPIVV;
        u.vs1_index = rs2 + vreg_idx_t'(idx);
        u.vs1_eew   = eew_of(sew_bits);
        u.vs1_valid = 1'b1;
      end else begin
        u.vs2_index = rs2 + vreg_idx_t'(idx);
        u.vs2_eew   = eew_of(vs2_bits);
        u.vs2_valid = 1'b1;
        u.imm_valid = 1'b1;
        if (op inside {F6_VSLL, F6_VSRL, F6_VSRA})
          u.imm_data = xlen_t'(rimm & (sew_bits - 1));
        else if (op inside {F6_VNSRL, F6_VNSRA})
          u.imm_data = xlen_t'(rimm & (2 * sew_bits - 1));
        else if (op == F6_VSLIDEUP)
          u.imm_data = xlen_t'(rimm);
        else
          u.imm_data = {{(XLEN-IMM_WIDTH){rimm[IMM_WIDTH-1]}}, rimm};
      end
      u.vstart    = (idx == first) ? in.vstart : vstart_t'(idx << sh);
      u.uop_index = uop_index_t'(idx);
      u.last      = idx == emul_max - 1;
      e.uop[i]    = u;
    end
    return e;
  endfunction

  // two-cycle delay of the prediction, matching the DUT latency
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_stage <= '0;
      exp_out   <= '0;
    end else begin
      exp_stage <= predict(inst_valid, inst, uop_index_remain);
      exp_out   <= exp_stage;
    end
  end

  assign exp_valid = exp_out.valid;
  assign exp_uop   = exp_out.uop;

  task automatic draw_fields();
    vld    = 1'b1;
    f6     = F6_VADD;
    f3     = F3_OPIVI;
    vm     = 1'(take_bits(1));
    vs2    = vreg_idx_t'(take_bits(5));
    imm    = vreg_idx_t'(take_bits(5));
    vd     = vreg_idx_t'(take_bits(5));
    sew    = vsew_t'(take_bits(2) % 3);
    // codes 110, 111, 000 .. 011
    lmul   = vlmul_t'((take_bits(3) % 6 + 6) % 8);
    vst    = '0;
    remain = '0;
  endtask

  task automatic shape_fields(int t);
    int regs;
    int nr;
    regs = lmul_regs(lmul);
    case (t)
      0: begin
        f6 = SINGLE_OPS[take_bits(4) % 11];
        if (f6 == F6_VADC)
          vm = 1'b0;
        if (f6 == F6_VMERGE && vm)
          vs2 = '0;
        vd     = align_to(vd, regs);
        vs2    = align_to(vs2, regs);
        remain = uop_index_t'(take_bits(3) % regs);
      end
      1: begin
        f6     = take_bits(1) ? F6_VMSNE : F6_VMSEQ;
        vs2    = align_to(vs2, regs);
        remain = uop_index_t'(take_bits(3) % regs);
      end
      2: begin
        f6  = take_bits(1) ? F6_VNSRA : F6_VNSRL;
        vd  = align_to(vd, regs);
        vs2 = align_to(vs2, 2 * regs);
      end
      3: begin
        // nr of 0, 1, 3 or 7, sometimes spoiled
        nr     = (1 << take_bits(2)) - 1;
        f6     = F6_VMVNRR;
        vm     = 1'b1;
        imm    = vreg_idx_t'(nr);
        vd     = align_to(vd, nr + 1);
        vs2    = align_to(vs2, nr + 1);
        remain = uop_index_t'(take_bits(3) % (nr + 1));
        if (take_bits(2) == 0) begin
          if (take_bits(1))
            vm = 1'b0;
          else
            imm = vreg_idx_t'(take_bits(5));
        end
      end
      4: begin
        case (take_bits(3) % 6)
          0: begin
            f6 = F6_VADC;
            vm = 1'b1;
          end
          1: begin
            f6  = F6_VMERGE;
            vm  = 1'b1;
            vs2 = vs2 | 5'd1;
          end
          2: begin
            lmul = vlmul_t'(1 + take_bits(2) % 3);
            vd   = vd | 5'd1;
          end
          3: begin
            lmul = vlmul_t'(1 + take_bits(2) % 3);
            vs2  = vs2 | 5'd1;
          end
          4: begin
            f3 = funct3_t'(take_bits(3));
            if (f3 == F3_OPIVI)
              f3 = F3_OPIVV;
          end
          default: f6 = UNKNOWN_OPS[take_bits(2)];
        endcase
      end
      default: begin
        f6     = START_OPS[take_bits(3) % 5];
        vm     = 1'b1;
        vd     = align_to(vd, 2 * regs);
        vs2    = align_to(vs2, 2 * regs);
        vst    = vstart_t'(take_bits(7));
        remain = uop_index_t'(take_bits(3));
        vld    = take_bits(2) != 0;
      end
    endcase
  endtask

  task automatic send_inst();
    @(negedge clk);
    inst_valid       = vld;
    inst.inst        = {f6, vm, vs2, imm, f3, vd, 2'b00};
    inst.vsew        = sew;
    inst.vlmul       = lmul;
    inst.vstart      = vst;
    uop_index_remain = remain;
  endtask

  task automatic drain();
    repeat (DRAIN) begin
      @(negedge clk);
      inst_valid = 1'b0;
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    clk              = 1'b0;
    arst_n           = 1'b0;
    inst_valid       = 1'b0;
    inst             = '0;
    uop_index_remain = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    for (int t = 0; t < NUM_TESTS; t++) begin
      seen = i_rvv_decode_top.i_rvv_decode_assertions.fail_count;
      for (int k = 0; k < VECTORS; k++) begin
        draw_fields();
        shape_fields(t);
        send_inst();
      end
      drain();
      $display("test %0d %s: %0d failures", t + 1, test_name(t),
               i_rvv_decode_top.i_rvv_decode_assertions.fail_count - seen);
    end

    total = i_rvv_decode_top.i_rvv_decode_assertions.fail_count;
    $display("%0d tests, %0d vectors, %0d failures", NUM_TESTS, NUM_TESTS * VECTORS, total);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/rvv_decode_assertions.sv ====
`timescale 1ns/1ps

module rvv_decode_assertions #(
  parameter int NUM_DE_UOP = 2
) (
  input logic                                  clk,
  input logic                                  arst_n,
  input logic                 [NUM_DE_UOP-1:0] uop_valid,
  input rvv_decode_pkg::uop_t [NUM_DE_UOP-1:0] uop,
  input logic                 [NUM_DE_UOP-1:0] exp_valid,
  input rvv_decode_pkg::uop_t [NUM_DE_UOP-1:0] exp_uop
);

  int fail_count = 0;

  // outputs stay cleared while reset is held
  reset_idle: assert property (@(posedge clk) !arst_n |-> uop_valid == '0)
    else begin
      $error("error uop_valid expected 0x0 in reset got 0x%h", $sampled(uop_valid));
      fail_count++;
    end

  valid_match: assert property (@(posedge clk) disable iff (!arst_n) uop_valid == exp_valid)
    else begin
      $error("error uop_valid expected 0x%h got 0x%h", $sampled(exp_valid),
             $sampled(uop_valid));
      fail_count++;
    end

  // contents only matter on slots that carry a uop
  for (genvar i = 0; i < NUM_DE_UOP; i++) begin : g_slot
    imm_match: assert property (@(posedge clk) disable iff (!arst_n)
      exp_valid[i] |-> uop[i].imm_data == exp_uop[i].imm_data)
      else begin
        $error("error uop[%0d].imm_data expected 0x%h got 0x%h", i,
               $sampled(exp_uop[i].imm_data), $sampled(uop[i].imm_data));
        fail_count++;
      end

    vstart_match: assert property (@(posedge clk) disable iff (!arst_n)
      exp_valid[i] |-> uop[i].vstart == exp_uop[i].vstart)
      else begin
        $error("error uop[%0d].vstart expected 0x%h got 0x%h", i,
               $sampled(exp_uop[i].vstart), $sampled(uop[i].vstart));
        fail_count++;
      end

    uop_match: assert property (@(posedge clk) disable iff (!arst_n)
      exp_valid[i] |-> uop[i] == exp_uop[i])
      else begin
        $error("error uop[%0d] expected 0x%h got 0x%h", i,
               $sampled(exp_uop[i]), $sampled(uop[i]));
        fail_count++;
      end
  end

endmodule

// ==== rtl/rvv_decode_top.sv ====
`timescale 1ns/1ps

module rvv_decode_top #(
  parameter int NUM_DE_UOP = 2
) (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        inst_valid,
  input  rvv_decode_pkg::inst_in_t                    inst,
  input  rvv_decode_pkg::uop_index_t                  uop_index_remain,
  output logic                       [NUM_DE_UOP-1:0] uop_valid,
  output rvv_decode_pkg::uop_t       [NUM_DE_UOP-1:0] uop
);
  import rvv_decode_pkg::*;

  logic         fields_valid;
  inst_fields_t fields;
  op_info_t     info;
  geometry_t    geom;

  // stage 1, registered instruction fields
  rvv_inst_capture i_rvv_inst_capture (
    .clk              (clk),
    .arst_n           (arst_n),
    .inst_valid       (inst_valid),
    .inst             (inst),
    .uop_index_remain (uop_index_remain),
    .fields_valid     (fields_valid),
    .fields           (fields)
  );

  rvv_op_classify i_rvv_op_classify (
    .fields (fields),
    .info   (info)
  );

  rvv_operand_geometry i_rvv_operand_geometry (
    .fields (fields),
    .info   (info),
    .geom   (geom)
  );

  // stage 2, registered micro-op vector
  rvv_uop_expand #(
    .NUM_DE_UOP (NUM_DE_UOP)
  ) i_rvv_uop_expand (
    .clk          (clk),
    .arst_n       (arst_n),
    .fields_valid (fields_valid),
    .fields       (fields),
    .info         (info),
    .geom         (geom),
    .uop_valid    (uop_valid),
    .uop          (uop)
  );

endmodule

// ==== rtl/rvv_uop_expand.sv ====
`timescale 1ns/1ps

module rvv_uop_expand #(
  parameter int NUM_DE_UOP = 2
) (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        fields_valid,
  input  rvv_decode_pkg::inst_fields_t                fields,
  input  rvv_decode_pkg::op_info_t                    info,
  input  rvv_decode_pkg::geometry_t                   geom,
  output logic                       [NUM_DE_UOP-1:0] uop_valid,
  output rvv_decode_pkg::uop_t       [NUM_DE_UOP-1:0] uop
);
  import rvv_decode_pkg::*;

  // log2 of elements per register for each element width
  localparam int SH8  = $clog2(VLEN / 8);
  localparam int SH16 = $clog2(VLEN / 16);
  localparam int SH32 = $clog2(VLEN / 32);

  int                          vsh;
  vstart_t                     uop_vstart;
  vstart_t                     uop_start;
  xlen_t                       imm_data;
  logic      [IMM_WIDTH-1:0]   imm;
  vstart_t                     idx       [NUM_DE_UOP];
  logic      [NUM_DE_UOP-1:0]  valid_d;
  uop_t      [NUM_DE_UOP-1:0]  uop_d;

  assign imm = fields.vs1_imm;

  // first uop touched by vstart
  always_comb begin
    case (geom.eew_max)
      EEW16:   vsh = SH16;
      EEW32:   vsh = SH32;
      default: vsh = SH8;
    endcase
    uop_vstart = vstart_t'(fields.vstart >> vsh);
    uop_start  = (uop_vstart >= vstart_t'(fields.uop_index_remain))
                 ? uop_vstart : vstart_t'(fields.uop_index_remain);
  end

  always_comb begin
    case (info.imm_kind)
      IMM_SIGNED: imm_data = {{(XLEN-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
      IMM_SHIFT: begin
        // shift amount limited to log2(SEW) bits
        case (geom.eew_vs1)
          EEW8:    imm_data = xlen_t'(imm[2:0]);
          EEW16:   imm_data = xlen_t'(imm[3:0]);
          default: imm_data = xlen_t'(imm);
        endcase
      end
      IMM_NSHIFT: imm_data = (geom.eew_vs1 == EEW8) ? xlen_t'(imm[3:0]) : xlen_t'(imm);
      default:    imm_data = (info.group == GRP_SLIDE) ? xlen_t'(imm) : '0;
    endcase
  end

  always_comb begin
    for (int i = 0; i < NUM_DE_UOP; i++) begin
      idx[i]     = uop_start + vstart_t'(i);
      valid_d[i] = fields_valid && geom.encoding_ok && (idx[i] < vstart_t'(geom.emul_max));

      uop_d[i]           = '0;
      uop_d[i].funct6    = fields.funct6;
      uop_d[i].funct3    = fields.funct3;
      uop_d[i].exe_unit  = info.exe_unit;
      uop_d[i].vm        = fields.vm;
      uop_d[i].v0_valid  = info.v0_valid;
      uop_d[i].vd_index  = fields.vd;
      uop_d[i].vd_eew    = geom.eew_vd;
      uop_d[i].vd_valid  = info.group != GRP_NONE;
      uop_d[i].vs3_valid = info.vs3_valid;
      if (info.vd_inc)
        uop_d[i].vd_index = fields.vd + vreg_idx_t'(idx[i][UOP_INDEX_WIDTH-1:0]);

      if (info.group == GRP_MOVE) begin
        // whole-register move becomes nr vmv.v.v uops
        uop_d[i].funct6    = F6_VMERGE;
        uop_d[i].funct3    = F3_OPIVV;
        uop_d[i].vs1_index = fields.vs2 + vreg_idx_t'(idx[i][UOP_INDEX_WIDTH-1:0]);
        uop_d[i].vs1_eew   = geom.eew_vs2;
        uop_d[i].vs1_valid = 1'b1;
      end else begin
        uop_d[i].vs2_index = fields.vs2 + vreg_idx_t'(idx[i][UOP_INDEX_WIDTH-1:0]);
        uop_d[i].vs2_eew   = geom.eew_vs2;
        uop_d[i].vs2_valid = 1'b1;
        uop_d[i].imm_data  = imm_data;
        uop_d[i].imm_valid = 1'b1;
      end

      // start slot carries the original vstart
      if (idx[i] == uop_vstart)
        uop_d[i].vstart = fields.vstart;
      else
        uop_d[i].vstart = vstart_t'(vstart_t'(idx[i][UOP_INDEX_WIDTH-1:0]) << vsh);

      uop_d[i].uop_index = idx[i][UOP_INDEX_WIDTH-1:0];
      uop_d[i].last      = idx[i] == vstart_t'(geom.emul_max - emul_t'(1));
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uop_valid <= '0;
      uop       <= '0;
    end else begin
      uop_valid <= valid_d;
      uop       <= uop_d;
    end
  end

endmodule

// ==== rtl/rvv_operand_geometry.sv ====
`timescale 1ns/1ps

module rvv_operand_geometry (
  input  rvv_decode_pkg::inst_fields_t fields,
  input  rvv_decode_pkg::op_info_t     info,
  output rvv_decode_pkg::geometry_t    geom
);
  import rvv_decode_pkg::*;

  emul_t lmul_emul;
  emul_t nr_emul;
  eew_t  sew_eew;
  logic  sew_ok;
  logic  frac;

  function automatic logic is_aligned(vreg_idx_t idx, emul_t emul);
    case (emul)
      emul_t'(2): return idx[0] == 1'b0;
      emul_t'(4): return idx[1:0] == 2'b00;
      emul_t'(8): return idx[2:0] == 3'b000;
      default:    return 1'b1;
    endcase
  endfunction

  // register count of vmv<nr>r
  assign nr_emul = emul_t'(fields.vs1_imm[2:0]) + emul_t'(1);
  assign frac    = (fields.vlmul == LMUL_1_4) || (fields.vlmul == LMUL_1_2);

  always_comb begin
    case (fields.vlmul)
      LMUL_1_4, LMUL_1_2, LMUL1: lmul_emul = emul_t'(1);
      LMUL2:                     lmul_emul = emul_t'(2);
      LMUL4:                     lmul_emul = emul_t'(4);
      LMUL8:                     lmul_emul = emul_t'(8);
      default:                   lmul_emul = '0;
    endcase

    sew_ok = 1'b1;
    case (fields.vsew)
      SEW8:    sew_eew = EEW8;
      SEW16:   sew_eew = EEW16;
      SEW32:   sew_eew = EEW32;
      default: begin
        sew_eew = EEW8;
        sew_ok  = 1'b0;
      end
    endcase
  end

  always_comb begin
    geom         = '0;
    geom.eew_vd  = sew_eew;
    geom.eew_vs2 = sew_eew;
    geom.eew_vs1 = sew_eew;

    case (info.group)
      GRP_SINGLE, GRP_SLIDE: begin
        geom.emul_vd  = lmul_emul;
        geom.emul_vs2 = lmul_emul;
      end
      GRP_COMPARE: begin
        geom.emul_vd  = (lmul_emul != '0) ? emul_t'(1) : '0;
        geom.emul_vs2 = lmul_emul;
        geom.eew_vd   = EEW1;
      end
      GRP_NARROW: begin
        // source is 2*SEW, so SEW32 and LMUL8 have no legal form
        geom.eew_vs2 = (sew_eew == EEW8) ? EEW16 : EEW32;
        if ((fields.vsew != SEW32) && (lmul_emul != emul_t'(8))) begin
          geom.emul_vd  = lmul_emul;
          geom.emul_vs2 = frac ? lmul_emul : emul_t'(lmul_emul << 1);
        end
      end
      GRP_MOVE: begin
        geom.emul_vd  = nr_emul;
        geom.emul_vs2 = nr_emul;
      end
      default: begin
        geom.emul_vd  = '0;
        geom.emul_vs2 = '0;
      end
    endcase

    if (!sew_ok) begin
      geom.emul_vd  = '0;
      geom.emul_vs2 = '0;
    end

    geom.emul_max    = (geom.emul_vs2 > geom.emul_vd) ? geom.emul_vs2 : geom.emul_vd;
    geom.eew_max     = (geom.eew_vs2 > geom.eew_vd) ? geom.eew_vs2 : geom.eew_vd;
    geom.encoding_ok = info.opcode_ok &&
                       is_aligned(fields.vd, geom.emul_vd) &&
                       is_aligned(fields.vs2, geom.emul_vs2);
  end

endmodule

// ==== rtl/rvv_op_classify.sv ====
`timescale 1ns/1ps

module rvv_op_classify (
  input  rvv_decode_pkg::inst_fields_t fields,
  output rvv_decode_pkg::op_info_t     info
);
  import rvv_decode_pkg::*;

  logic known;
  logic legal;
  logic nr_ok;

  // nr field of vmv<nr>r holds nreg-1
  assign nr_ok = (fields.vs1_imm[4:3] == 2'b00) &&
                 ((fields.vs1_imm[2:0] == 3'd0) || (fields.vs1_imm[2:0] == 3'd1) ||
                  (fields.vs1_imm[2:0] == 3'd3) || (fields.vs1_imm[2:0] == 3'd7));

  always_comb begin
    info          = '0;
    info.group    = GRP_NONE;
    info.exe_unit = ALU;
    info.imm_kind = IMM_SIGNED;
    known         = 1'b1;
    legal         = 1'b1;

    case (fields.funct6)
      F6_VADD, F6_VRSUB, F6_VAND, F6_VOR, F6_VXOR: begin
        info.group = GRP_SINGLE;
      end
      F6_VADC: begin
        // carry in always comes from v0
        info.group    = GRP_SINGLE;
        info.v0_valid = 1'b1;
        legal         = !fields.vm;
      end
      F6_VMERGE: begin
        // vm=1 is vmv.v.i, vs2 must be zero
        info.group    = GRP_SINGLE;
        info.v0_valid = !fields.vm;
        legal         = !fields.vm || (fields.vs2 == '0);
      end
      F6_VSLL, F6_VSRL, F6_VSRA: begin
        info.group    = GRP_SINGLE;
        info.imm_kind = IMM_SHIFT;
      end
      F6_VMSEQ, F6_VMSNE: begin
        info.group     = GRP_COMPARE;
        info.vs3_valid = 1'b1;
      end
      F6_VNSRL, F6_VNSRA: begin
        info.group    = GRP_NARROW;
        info.imm_kind = IMM_NSHIFT;
      end
      F6_VSLIDEUP: begin
        info.group    = GRP_SLIDE;
        info.exe_unit = PMTRDT;
        info.imm_kind = IMM_NONE;
      end
      F6_VMVNRR: begin
        info.group    = GRP_MOVE;
        info.imm_kind = IMM_NONE;
        legal         = fields.vm && nr_ok;
      end
      default: begin
        known = 1'b0;
      end
    endcase

    // mask results land in a single register
    info.vd_inc    = known && (info.group != GRP_COMPARE);
    info.opcode_ok = known && legal && (fields.funct3 == F3_OPIVI);
  end

endmodule

// ==== rtl/rvv_inst_capture.sv ====
`timescale 1ns/1ps

module rvv_inst_capture (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         inst_valid,
  input  rvv_decode_pkg::inst_in_t     inst,
  input  rvv_decode_pkg::uop_index_t   uop_index_remain,
  output logic                         fields_valid,
  output rvv_decode_pkg::inst_fields_t fields
);
  import rvv_decode_pkg::*;

  inst_fields_t fields_d;

  // field positions of the compressed encoding
  always_comb begin
    fields_d.funct6           = inst.inst[26:21];
    fields_d.vm               = inst.inst[20];
    fields_d.vs2              = inst.inst[19:15];
    fields_d.vs1_imm          = inst.inst[14:10];
    fields_d.funct3           = inst.inst[9:7];
    fields_d.vd               = inst.inst[6:2];
    fields_d.vsew             = inst.vsew;
    fields_d.vlmul            = inst.vlmul;
    fields_d.vstart           = inst.vstart;
    fields_d.uop_index_remain = uop_index_remain;
  end

  // loaded every cycle, fields_valid qualifies the contents
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fields_valid <= 1'b0;
      fields       <= '0;
    end else begin
      fields_valid <= inst_valid;
      fields       <= fields_d;
    end
  end

endmodule

// ==== rtl/rvv_decode_pkg.sv ====
package rvv_decode_pkg;

  parameter int VLEN            = 128;
  parameter int XLEN            = 32;
  parameter int UOP_INDEX_WIDTH = 3;
  parameter int VSTART_WIDTH    = 7;
  parameter int IMM_WIDTH       = 5;
  parameter int REG_IDX_WIDTH   = 5;

  typedef logic [REG_IDX_WIDTH-1:0]   vreg_idx_t;
  typedef logic [UOP_INDEX_WIDTH-1:0] uop_index_t;
  // group size 0..8, one bit wider than a uop index
  typedef logic [UOP_INDEX_WIDTH:0]   emul_t;
  typedef logic [VSTART_WIDTH-1:0]    vstart_t;
  typedef logic [XLEN-1:0]            xlen_t;
  // encoding with the 5-bit major opcode stripped
  typedef logic [26:0]                inst_bits_t;

  typedef logic [5:0] funct6_t;
  localparam funct6_t F6_VADD     = 6'b000000;
  localparam funct6_t F6_VRSUB    = 6'b000011;
  localparam funct6_t F6_VAND     = 6'b001001;
  localparam funct6_t F6_VOR      = 6'b001010;
  localparam funct6_t F6_VXOR     = 6'b001011;
  localparam funct6_t F6_VSLIDEUP = 6'b001110;
  localparam funct6_t F6_VADC     = 6'b010000;
  localparam funct6_t F6_VMERGE   = 6'b010111;
  localparam funct6_t F6_VMSEQ    = 6'b011000;
  localparam funct6_t F6_VMSNE    = 6'b011001;
  localparam funct6_t F6_VSLL     = 6'b100101;
  localparam funct6_t F6_VMVNRR   = 6'b100111;
  localparam funct6_t F6_VSRL     = 6'b101000;
  localparam funct6_t F6_VSRA     = 6'b101001;
  localparam funct6_t F6_VNSRL    = 6'b101100;
  localparam funct6_t F6_VNSRA    = 6'b101101;

  typedef logic [2:0] funct3_t;
  localparam funct3_t F3_OPIVV = 3'b000;
  localparam funct3_t F3_OPIVI = 3'b011;

  typedef logic [2:0] vsew_t;
  localparam vsew_t SEW8  = 3'b000;
  localparam vsew_t SEW16 = 3'b001;
  localparam vsew_t SEW32 = 3'b010;

  typedef logic [2:0] vlmul_t;
  localparam vlmul_t LMUL_1_4 = 3'b110;
  localparam vlmul_t LMUL_1_2 = 3'b111;
  localparam vlmul_t LMUL1    = 3'b000;
  localparam vlmul_t LMUL2    = 3'b001;
  localparam vlmul_t LMUL4    = 3'b010;
  localparam vlmul_t LMUL8    = 3'b011;

  // ordered so that a larger code is a wider element
  typedef logic [1:0] eew_t;
  localparam eew_t EEW1  = 2'd0;
  localparam eew_t EEW8  = 2'd1;
  localparam eew_t EEW16 = 2'd2;
  localparam eew_t EEW32 = 2'd3;

  typedef logic [2:0] op_group_t;
  localparam op_group_t GRP_NONE    = 3'd0;
  localparam op_group_t GRP_SINGLE  = 3'd1;
  localparam op_group_t GRP_COMPARE = 3'd2;
  localparam op_group_t GRP_NARROW  = 3'd3;
  localparam op_group_t GRP_SLIDE   = 3'd4;
  localparam op_group_t GRP_MOVE    = 3'd5;

  typedef logic [1:0] imm_kind_t;
  localparam imm_kind_t IMM_SIGNED = 2'd0;
  localparam imm_kind_t IMM_SHIFT  = 2'd1;
  localparam imm_kind_t IMM_NSHIFT = 2'd2;
  localparam imm_kind_t IMM_NONE   = 2'd3;

  typedef logic exe_unit_t;
  localparam exe_unit_t ALU    = 1'b0;
  localparam exe_unit_t PMTRDT = 1'b1;

  typedef struct packed {
    inst_bits_t inst;
    vsew_t      vsew;
    vlmul_t     vlmul;
    vstart_t    vstart;
  } inst_in_t;

  typedef struct packed {
    funct6_t    funct6;
    funct3_t    funct3;
    logic       vm;
    vreg_idx_t  vs2;
    vreg_idx_t  vs1_imm;
    vreg_idx_t  vd;
    vsew_t      vsew;
    vlmul_t     vlmul;
    vstart_t    vstart;
    uop_index_t uop_index_remain;
  } inst_fields_t;

  typedef struct packed {
    op_group_t group;
    exe_unit_t exe_unit;
    imm_kind_t imm_kind;
    logic      opcode_ok;
    logic      v0_valid;
    logic      vs3_valid;
    logic      vd_inc;
  } op_info_t;

  typedef struct packed {
    emul_t emul_vd;
    emul_t emul_vs2;
    emul_t emul_max;
    eew_t  eew_vd;
    eew_t  eew_vs2;
    eew_t  eew_vs1;
    eew_t  eew_max;
    logic  encoding_ok;
  } geometry_t;

  typedef struct packed {
    funct3_t    funct3;
    funct6_t    funct6;
    exe_unit_t  exe_unit;
    logic       vm;
    logic       v0_valid;
    vreg_idx_t  vd_index;
    eew_t       vd_eew;
    logic       vd_valid;
    logic       vs3_valid;
    vreg_idx_t  vs1_index;
    eew_t       vs1_eew;
    logic       vs1_valid;
    vreg_idx_t  vs2_index;
    eew_t       vs2_eew;
    logic       vs2_valid;
    xlen_t      imm_data;
    logic       imm_valid;
    vstart_t    vstart;
    uop_index_t uop_index;
    logic       last;
  } uop_t;

endpackage
